/* verilog/cctag_defines.svh */
`ifndef CCTAG_DEFINES_SVH
`define CCTAG_DEFINES_SVH

// ---------------------------------------------------------------------------
// Directory geometry
// ---------------------------------------------------------------------------

// Associativity of the directory.
`define CCTAG_WAYS 4

// The index is 7 bits wide, so the directory holds 128 sets.
`define CCTAG_SET_BITS 7

// Physical line address width without the byte offset within a line.
`define CCTAG_LINE_BITS 37

`endif

/* verilog/cctag_addr_pkg.sv */
`include "cctag_defines.svh"

package cctag_addr_pkg;

  localparam int TAG_BITS = `CCTAG_LINE_BITS - `CCTAG_SET_BITS; // 30 bits of tag.

  typedef struct packed {
    logic [TAG_BITS-1:0]        tag;
    logic [`CCTAG_SET_BITS-1:0] index;
  } line_fields_t;

  // A line address is used whole on the eviction port and split for the lookup.
  typedef union packed {
    logic [`CCTAG_LINE_BITS-1:0] raw;
    line_fields_t                fields;
  } line_addr_u;

  // Even parity over the whole word, so an all-zero word is a clean invalid entry.
  typedef struct packed {
    logic                parity;
    logic                valid;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

endpackage

/* verilog/cctag_ctl_pkg.sv */
`include "cctag_defines.svh"

package cctag_ctl_pkg;

  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_FILL   = 2'd1,
    OP_INVAL  = 2'd2
  } op_e;

  typedef logic [$clog2(`CCTAG_WAYS)-1:0] way_t;

  // Tree pseudo-LRU bits for one set.
  typedef logic [2:0] plru_t;

  // ---------------------------------------------------------------------------
  // Replacement helpers
  // ---------------------------------------------------------------------------

  function automatic way_t plru_victim(input plru_t bits);
    if (bits[0]) begin
      return way_t'({1'b1, bits[2]}); // Victim in the upper pair.
    end
    return way_t'({1'b0, bits[1]});
  endfunction

  function automatic plru_t plru_touch(input plru_t bits, input way_t way);
    plru_t next;
    next = bits;
    if (way[1]) begin
      next[0] = 1'b0; // Point the root at the lower pair.
      next[2] = ~way[0];
    end else begin
      next[0] = 1'b1;
      next[1] = ~way[0];
    end
    return next;
  endfunction

endpackage

/* verilog/cctag_if.sv */
`timescale 1ns/1ns
`include "cctag_defines.svh"

// ---------------------------------------------------------------------------
// Lookup to resolve
// ---------------------------------------------------------------------------

interface cctag_read_if;
  logic                      valid;
  cctag_ctl_pkg::op_e        op;
  cctag_addr_pkg::line_addr_u addr;
  cctag_ctl_pkg::plru_t      plru;
  cctag_addr_pkg::tag_entry_t entries [`CCTAG_WAYS]; // Tag words of the addressed set.

  modport source (output valid, output op, output addr, output plru, output entries);
  modport sink (input valid, input op, input addr, input plru, input entries);
endinterface

// ---------------------------------------------------------------------------
// Resolve to update
// ---------------------------------------------------------------------------

interface cctag_result_if;
  logic                       valid;
  cctag_ctl_pkg::op_e         op;
  cctag_addr_pkg::line_addr_u addr;
  logic                       hit;
  logic                       err;
  cctag_ctl_pkg::way_t        way;
  logic                       evict;
  cctag_addr_pkg::line_addr_u evict_addr;
  cctag_ctl_pkg::plru_t       plru_next;

  modport source (output valid, output op, output addr, output hit, output err,
                  output way, output evict, output evict_addr, output plru_next);
  modport sink (input valid, input op, input addr, input hit, input err,
                input way, input evict, input evict_addr, input plru_next);
endinterface

// ---------------------------------------------------------------------------
// Update back to the RAMs in lookup
// ---------------------------------------------------------------------------

interface cctag_write_if;
  logic                       tag_wen;
  cctag_ctl_pkg::way_t        tag_way;
  logic [`CCTAG_SET_BITS-1:0] tag_index;
  cctag_addr_pkg::tag_entry_t tag_data;
  logic                       plru_wen;
  logic [`CCTAG_SET_BITS-1:0] plru_index;
  cctag_ctl_pkg::plru_t       plru_data;
  logic                       busy; // High while the init sweep runs.

  modport source (output tag_wen, output tag_way, output tag_index, output tag_data,
                  output plru_wen, output plru_index, output plru_data, output busy);
  modport sink (input tag_wen, input tag_way, input tag_index, input tag_data,
                input plru_wen, input plru_index, input plru_data, input busy);
endinterface

/* verilog/cctag_ram.sv */
`timescale 1ns/1ns

module cctag_ram #(
  parameter int WIDTH      = 32,
  parameter int DEPTH_BITS = 7
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  read_en,
  input  logic [DEPTH_BITS-1:0] read_addr,
  output logic [WIDTH-1:0]      read_data,
  input  logic                  write_en,
  input  logic [DEPTH_BITS-1:0] write_addr,
  input  logic [WIDTH-1:0]      write_data
);

  logic [WIDTH-1:0]      mem [2**DEPTH_BITS];
  logic [DEPTH_BITS-1:0] read_addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      read_addr_q <= '0;
    end else if (read_en) begin
      read_addr_q <= read_addr; // Data holds until the next accepted read.
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

  assign read_data = mem[read_addr_q];

endmodule

/* verilog/cctag_lookup.sv */
`timescale 1ns/1ns
`include "cctag_defines.svh"

module cctag_lookup (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid,
  input  cctag_ctl_pkg::op_e         req_op,
  input  cctag_addr_pkg::line_addr_u req_addr,
  cctag_write_if.sink                wr,
  cctag_read_if.source               rd
);

  logic                   accept;
  logic [`CCTAG_WAYS-1:0] way_wen;

  assign accept = req_valid && !wr.busy; // Requests during the sweep are dropped.

  for (genvar i = 0; i < `CCTAG_WAYS; i++) begin : g_way
    // The sweep clears every way of a set at once.
    assign way_wen[i] = wr.tag_wen && (wr.busy || wr.tag_way == cctag_ctl_pkg::way_t'(i));

    cctag_ram #(
      .WIDTH      ($bits(cctag_addr_pkg::tag_entry_t)),
      .DEPTH_BITS (`CCTAG_SET_BITS)
    ) i_tag_ram (
      .clk        (clk),
      .rst        (rst),
      .read_en    (accept),
      .read_addr  (req_addr.fields.index),
      .read_data  (rd.entries[i]),
      .write_en   (way_wen[i]),
      .write_addr (wr.tag_index),
      .write_data (wr.tag_data)
    );
  end

  cctag_ram #(
    .WIDTH      ($bits(cctag_ctl_pkg::plru_t)),
    .DEPTH_BITS (`CCTAG_SET_BITS)
  ) i_plru_ram (
    .clk        (clk),
    .rst        (rst),
    .read_en    (accept),
    .read_addr  (req_addr.fields.index),
    .read_data  (rd.plru),
    .write_en   (wr.plru_wen),
    .write_addr (wr.plru_index),
    .write_data (wr.plru_data)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      rd.valid <= 1'b0;
    end else begin
      rd.valid <= accept;
    end
    if (accept) begin
      rd.op   <= req_op;
      rd.addr <= req_addr;
    end
  end

endmodule

/* verilog/cctag_resolve.sv */
`timescale 1ns/1ns
`include "cctag_defines.svh"

module cctag_resolve (
  input  logic           clk,
  input  logic           rst,
  cctag_read_if.sink     rd,
  cctag_result_if.source res
);

  logic [`CCTAG_WAYS-1:0]     hit_vec;
  logic [`CCTAG_WAYS-1:0]     free_vec;
  logic                       any_err;
  cctag_ctl_pkg::way_t        hit_way;
  cctag_ctl_pkg::way_t        free_way;
  cctag_ctl_pkg::way_t        pick_way;
  logic                       is_fill;
  logic                       do_evict;
  logic                       touch;
  cctag_addr_pkg::line_addr_u victim_line;

  // ---------------------------------------------------------------------------
  // Tag compare and parity
  // ---------------------------------------------------------------------------

  always_comb begin
    hit_vec  = '0;
    free_vec = '0;
    any_err  = 1'b0;
    hit_way  = '0;
    free_way = '0;
    // Walk downwards so the lowest matching way wins.
    for (int i = `CCTAG_WAYS - 1; i >= 0; i--) begin
      hit_vec[i]  = rd.entries[i].valid && rd.entries[i].tag == rd.addr.fields.tag;
      free_vec[i] = !rd.entries[i].valid;
      any_err     = any_err | (^rd.entries[i]);
      if (hit_vec[i]) begin
        hit_way = cctag_ctl_pkg::way_t'(i);
      end
      if (free_vec[i]) begin
        free_way = cctag_ctl_pkg::way_t'(i);
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Way choice and replacement
  // ---------------------------------------------------------------------------

  assign is_fill  = rd.op == cctag_ctl_pkg::OP_FILL;
  assign pick_way = (|hit_vec) ? hit_way :
                    (is_fill && |free_vec) ? free_way :
                    cctag_ctl_pkg::plru_victim(rd.plru);
  assign do_evict = is_fill && !(|hit_vec) && !(|free_vec); // The set is full, so the victim is valid.
  assign touch    = is_fill || (rd.op == cctag_ctl_pkg::OP_LOOKUP && |hit_vec);

  assign victim_line.raw = {rd.entries[pick_way].tag, rd.addr.fields.index};

  always_ff @(posedge clk) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= rd.valid;
    end
    if (rd.valid) begin
      res.op         <= rd.op;
      res.addr       <= rd.addr;
      res.hit        <= |hit_vec;
      res.err        <= any_err;
      res.way        <= pick_way;
      res.evict      <= do_evict;
      res.evict_addr <= victim_line;
      res.plru_next  <= touch ? cctag_ctl_pkg::plru_touch(rd.plru, pick_way) : rd.plru;
    end
  end

endmodule

/* verilog/cctag_update.sv */
`timescale 1ns/1ns
`include "cctag_defines.svh"

module cctag_update (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        init,
  cctag_result_if.sink                res,
  cctag_write_if.source               wr,
  output logic                        resp_valid,
  output logic                        resp_hit,
  output cctag_ctl_pkg::way_t         resp_way,
  output logic                        resp_err,
  output logic                        evict_valid,
  output logic [`CCTAG_LINE_BITS-1:0] evict_addr
);

  logic                       sweep_on;
  logic [`CCTAG_SET_BITS-1:0] sweep_idx;
  logic                       do_fill;
  logic                       do_inval;
  logic                       do_touch;
  cctag_addr_pkg::tag_entry_t fill_entry;

  // ---------------------------------------------------------------------------
  // Init sweep, one set per cycle
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_on  <= 1'b0;
      sweep_idx <= '0;
    end else if (init) begin
      sweep_on  <= 1'b1;
      sweep_idx <= '0;
    end else if (sweep_on) begin
      sweep_idx <= sweep_idx + 1'b1;
      if (&sweep_idx) begin
        sweep_on <= 1'b0; // Last set written on this edge.
      end
    end
  end

  assign wr.busy = sweep_on;

  assign do_fill  = res.valid && res.op == cctag_ctl_pkg::OP_FILL;
  assign do_inval = res.valid && res.op == cctag_ctl_pkg::OP_INVAL && res.hit;
  assign do_touch = do_fill || (res.valid && res.op == cctag_ctl_pkg::OP_LOOKUP && res.hit);

  assign fill_entry.valid  = 1'b1;
  assign fill_entry.tag    = res.addr.fields.tag;
  assign fill_entry.parity = ^{1'b1, res.addr.fields.tag};

  // The sweep owns the write ports while it runs.
  assign wr.tag_wen    = sweep_on || do_fill || do_inval;
  assign wr.tag_way    = res.way;
  assign wr.tag_index  = sweep_on ? sweep_idx : res.addr.fields.index;
  assign wr.tag_data   = (do_fill && !sweep_on) ? fill_entry : '0;
  assign wr.plru_wen   = sweep_on || do_touch;
  assign wr.plru_index = wr.tag_index;
  assign wr.plru_data  = sweep_on ? '0 : res.plru_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid  <= 1'b0;
      resp_hit    <= 1'b0;
      resp_err    <= 1'b0;
      evict_valid <= 1'b0;
    end else begin
      resp_valid  <= res.valid;
      resp_hit    <= res.valid && res.hit;
      resp_err    <= res.valid && res.err;
      evict_valid <= res.valid && res.evict;
    end
    if (res.valid) begin
      resp_way   <= res.way;
      evict_addr <= res.evict_addr.raw;
    end
  end

endmodule

/* verilog/cctag_top.sv */
`timescale 1ns/1ns
`include "cctag_defines.svh"

module cctag_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req_valid,
  input  cctag_ctl_pkg::op_e          req_op,
  input  logic [`CCTAG_LINE_BITS-1:0] req_addr,
  input  logic                        init,
  output logic                        busy,
  output logic                        resp_valid,
  output logic                        resp_hit,
  output cctag_ctl_pkg::way_t         resp_way,
  output logic                        resp_err,
  output logic                        evict_valid,
  output logic [`CCTAG_LINE_BITS-1:0] evict_addr
);

  cctag_read_if   rd_if ();
  cctag_result_if res_if ();
  cctag_write_if  wr_if ();

  assign busy = wr_if.busy;

  cctag_lookup i_lookup (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_op    (req_op),
    .req_addr  (req_addr),
    .wr        (wr_if.sink),
    .rd        (rd_if.source)
  );

  cctag_resolve i_resolve (
    .clk (clk),
    .rst (rst),
    .rd  (rd_if.sink),
    .res (res_if.source)
  );

  cctag_update i_update (
    .clk         (clk),
    .rst         (rst),
    .init        (init),
    .res         (res_if.sink),
    .wr          (wr_if.source),
    .resp_valid  (resp_valid),
    .resp_hit    (resp_hit),
    .resp_way    (resp_way),
    .resp_err    (resp_err),
    .evict_valid (evict_valid),
    .evict_addr  (evict_addr)
  );

endmodule

/* test/cctag_asserts.sv */
`timescale 1ns/1ns

module cctag_asserts (
  input logic clk,
  input logic rst,
  input logic req_valid,
  input logic init,
  input logic busy,
  input logic resp_valid,
  input logic resp_err,
  input logic evict_valid
);

  int fail_count = 0;
  int busy_run; // Consecutive cycles with busy high.

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_run <= 0;
    end else if (busy) begin
      busy_run <= busy_run + 1;
    end else begin
      busy_run <= 0;
    end
  end

  // ---------------------------------------------------------------------------
  // Init sweep
  // ---------------------------------------------------------------------------

  a_init_busy: assert property (@(posedge clk) disable iff (rst) init && !busy |=> busy)
    else begin
      fail_count++;
      $error("busy did not rise after init");
    end

  a_busy_bound: assert property (@(posedge clk) disable iff (rst) busy |-> busy_run < 128)
    else begin
      fail_count++;
      $error("busy stayed high longer than the sweep");
    end

  a_busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> busy_run == 128)
    else begin
      fail_count++;
      $error("busy fell after %0d cycles", busy_run);
    end

  // ---------------------------------------------------------------------------
  // Responses
  // ---------------------------------------------------------------------------

  // The response is sampled three edges after the edge that took the request.
  a_latency: assert property (@(posedge clk) disable iff (rst)
      resp_valid == $past(req_valid && !busy, 3))
    else begin
      fail_count++;
      $error("resp_valid does not follow an accepted request");
    end

  a_evict: assert property (@(posedge clk) disable iff (rst) evict_valid |-> resp_valid)
    else begin
      fail_count++;
      $error("evict_valid without resp_valid");
    end

  a_parity: assert property (@(posedge clk) disable iff (rst) resp_valid |-> !resp_err)
    else begin
      fail_count++;
      $error("parity error reported");
    end

endmodule

bind cctag_top cctag_asserts i_asserts (
  .clk         (clk),
  .rst         (rst),
  .req_valid   (req_valid),
  .init        (init),
  .busy        (busy),
  .resp_valid  (resp_valid),
  .resp_err    (resp_err),
  .evict_valid (evict_valid)
);

/* test/cctag_tb.sv */
`timescale 1ns/1ns
`include "cctag_defines.svh"

module cctag_tb;

  logic                        clk = 1'b0;
  logic                        rst;
  logic                        req_valid;
  cctag_ctl_pkg::op_e          req_op;
  logic [`CCTAG_LINE_BITS-1:0] req_addr;
  logic                        init;
  logic                        busy;
  logic                        resp_valid;
  logic                        resp_hit;
  cctag_ctl_pkg::way_t         resp_way;
  logic                        resp_err;
  logic                        evict_valid;
  logic [`CCTAG_LINE_BITS-1:0] evict_addr;

  logic [31:0] lfsr = 32'h9eb1c102;
  int          checks = 0;
  int          errors = 0;

  // Model of the four sets that the stimulus touches.
  logic [29:0] model_tag   [4][4];
  logic        model_valid [4][4];
  logic [2:0]  model_plru  [4];

  cctag_top i_cctag_top (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_op      (req_op),
    .req_addr    (req_addr),
    .init        (init),
    .busy        (busy),
    .resp_valid  (resp_valid),
    .resp_hit    (resp_hit),
    .resp_way    (resp_way),
    .resp_err    (resp_err),
    .evict_valid (evict_valid),
    .evict_addr  (evict_addr)
  );

  always #4 clk = ~clk;

  // ---------------------------------------------------------------------------
  // Random numbers and reference rules
  // ---------------------------------------------------------------------------

  function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // Taps 32, 22, 2, 1.
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Four sets spread over the index space hold eight tags each.
  function automatic logic [36:0] make_addr(input int set, input int k);
    return {k[2:0], 27'h2a3c0f1, set[1:0], 5'h16};
  endfunction

  function automatic int victim_of(input logic [2:0] bits);
    if (bits[0]) begin
      return bits[2] ? 3 : 2;
    end
    return bits[1] ? 1 : 0;
  endfunction

  function automatic logic [2:0] touched(input logic [2:0] bits, input int way);
    logic [2:0] next;
    next = bits;
    if (way >= 2) begin
      next[0] = 1'b0;      // Root now points at ways 0 and 1.
      next[2] = way == 2;
    end else begin
      next[0] = 1'b1;
      next[1] = way == 0;
    end
    return next;
  endfunction

  // ---------------------------------------------------------------------------
  // Checking and run control
  // ---------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    int assert_fails;
    assert_fails = i_cctag_top.i_asserts.fail_count;
    $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic run_init();
    bit done;
    done = 1'b0;
    @(posedge clk);
    init <= 1'b1;
    @(posedge clk);
    init <= 1'b0;
    @(posedge clk);
    check_value("busy", 64'(busy), 64'd1);
    for (int i = 0; i < 16; i++) begin
      req_valid <= 1'b1; // Dropped, since the sweep is running.
      req_op    <= cctag_ctl_pkg::OP_FILL;
      req_addr  <= make_addr(i % 4, i % 8);
      @(posedge clk);
      check_value("resp_valid", 64'(resp_valid), 64'd0);
    end
    req_valid <= 1'b0;
    for (int i = 0; i < 200 && !done; i++) begin
      @(posedge clk);
      check_value("resp_valid", 64'(resp_valid), 64'd0);
      done = !busy;
    end
    if (!done) begin
      report_timeout("the init sweep to end");
    end else begin
      for (int s = 0; s < 4; s++) begin
        model_plru[s] = 3'b000;
        for (int w = 0; w < 4; w++) begin
          model_valid[s][w] = 1'b0;
        end
      end
    end
  endtask

  task automatic do_op(input cctag_ctl_pkg::op_e op, input int set, input int k);
    logic [29:0] tag;
    logic [36:0] addr;
    logic [36:0] exp_evict_addr;
    logic        exp_evict;
    int          hit_w;
    int          free_w;
    int          exp_way;
    int          lat;
    bit          seen;
    addr           = make_addr(set, k);
    tag            = addr[36:7];
    hit_w          = -1;
    free_w         = -1;
    exp_evict      = 1'b0;
    exp_evict_addr = '0;
    lat            = 0;
    seen           = 1'b0;
    for (int w = 3; w >= 0; w--) begin
      if (model_valid[set][w] && model_tag[set][w] == tag) begin
        hit_w = w;
      end
      if (!model_valid[set][w]) begin
        free_w = w;
      end
    end
    exp_way = hit_w;
    if (op == cctag_ctl_pkg::OP_FILL) begin
      if (hit_w < 0 && free_w >= 0) begin
        exp_way = free_w;
      end else if (hit_w < 0) begin
        exp_way        = victim_of(model_plru[set]);
        exp_evict      = 1'b1;
        exp_evict_addr = {model_tag[set][exp_way], addr[6:0]};
      end
      model_tag[set][exp_way]   = tag;
      model_valid[set][exp_way] = 1'b1;
      model_plru[set]           = touched(model_plru[set], exp_way);
    end else if (op == cctag_ctl_pkg::OP_LOOKUP && hit_w >= 0) begin
      model_plru[set] = touched(model_plru[set], hit_w);
    end else if (op == cctag_ctl_pkg::OP_INVAL && hit_w >= 0) begin
      model_valid[set][hit_w] = 1'b0;
    end

    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    @(posedge clk);
    req_valid <= 1'b0;
    for (int i = 0; i < 8 && !seen; i++) begin
      @(posedge clk);
      seen = resp_valid;
      lat  = i;
    end
    if (!seen) begin
      report_timeout("resp_valid");
    end else begin
      check_value("resp_valid latency", 64'(lat), 64'd2);
      check_value("resp_hit", 64'(resp_hit), 64'(hit_w >= 0));
      check_value("resp_err", 64'(resp_err), 64'd0);
      check_value("evict_valid", 64'(evict_valid), 64'(exp_evict));
      if (hit_w >= 0 || op == cctag_ctl_pkg::OP_FILL) begin
        check_value("resp_way", 64'(resp_way), 64'(exp_way));
      end
      if (exp_evict) begin
        check_value("evict_addr", 64'(evict_addr), 64'(exp_evict_addr));
      end
    end
  endtask

  task automatic random_op(input bit lookups_only);
    cctag_ctl_pkg::op_e op;
    int                 r;
    int                 set;
    int                 k;
    r   = random_bits(2);
    set = random_bits(2);
    k   = random_bits(3);
    if (lookups_only || r == 0) begin
      op = cctag_ctl_pkg::OP_LOOKUP;
    end else if (r == 2) begin
      op = cctag_ctl_pkg::OP_INVAL;
    end else begin
      op = cctag_ctl_pkg::OP_FILL; // Fills are twice as likely, so sets fill up.
    end
    do_op(op, set, k);
  endtask

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------

  initial begin
    rst       = 1'b1;
    req_valid = 1'b0;
    req_op    = cctag_ctl_pkg::OP_LOOKUP;
    req_addr  = '0;
    init      = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    run_init();
    for (int i = 0; i < 8; i++) begin
      random_op(1'b1);
    end
    for (int i = 0; i < 300; i++) begin
      random_op(1'b0);
    end
    run_init(); // Everything filled so far must be gone.
    for (int i = 0; i < 16; i++) begin
      random_op(1'b1);
    end
    finish_run();
  end

endmodule

/* sources.f */
+incdir+verilog
verilog/cctag_addr_pkg.sv
verilog/cctag_ctl_pkg.sv
verilog/cctag_if.sv
verilog/cctag_ram.sv
verilog/cctag_lookup.sv
verilog/cctag_resolve.sv
verilog/cctag_update.sv
verilog/cctag_top.sv
test/cctag_asserts.sv
test/cctag_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = cctag_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+100
PASS_MSG  = Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
